// File: flist.f
fpu_pkg.sv
fpu_compare.sv
fpu_d2l.sv
fpu_l2d.sv
fpu_top.sv
tb_fpu_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the FPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_fpu_top -o tb_fpu_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_fpu_top > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
if ! grep -qF "*** TEST PASSED ***" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// File: tb_fpu_top.sv
// Testbench for the FPU dispatcher with reset and busy checks and a table of compares and conversions
module tb_fpu_top import fpu_pkg::*; ();

    logic                       i_clk;
    logic                       i_nrst;
    logic                       i_ena;
    logic [INSTR_FPU_TOTAL-1:0] i_ivec;
    logic [63:0]                i_a;
    logic [63:0]                i_b;
    logic [63:0]                o_res;
    logic                       o_ex_invalidop;
    logic                       o_ex_inexact;
    logic                       o_valid;
    logic                       o_busy;

    // Test table, one entry per row across all queues
    int          t_instr[$];
    logic [63:0] t_a[$];
    logic [63:0] t_b[$];
    logic [63:0] t_res[$];
    logic        t_inv[$];
    logic        t_inx[$];
    int          t_lat[$];

    int cycles;
    int cycle_limit;

    fpu_top dut0 (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_ena          (i_ena),
        .i_ivec         (i_ivec),
        .i_a            (i_a),
        .i_b            (i_b),
        .o_res          (o_res),
        .o_ex_invalidop (o_ex_invalidop),
        .o_ex_inexact   (o_ex_inexact),
        .o_valid        (o_valid),
        .o_busy         (o_busy)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // Watchdog on total run length
    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: no end of test after %0d clock cycles", cycles);
            $display("*** TEST FAILED ***");
            $fatal(1, "Run aborted");
        end
    end

    task automatic report_mismatch(input string what);
        $display("FAILED at time %0t: %s", $time, what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Check failed");
    endtask

    task automatic add_row(input int instr, input logic [63:0] a, input logic [63:0] b,
                           input logic [63:0] res, input logic inv, input logic inx,
                           input int lat);
        t_instr.push_back(instr);
        t_a.push_back(a);
        t_b.push_back(b);
        t_res.push_back(res);
        t_inv.push_back(inv);
        t_inx.push_back(inx);
        t_lat.push_back(lat);
    endtask

    // Expected values worked out by hand from the IEEE 754 rules
    task automatic build_table;
        add_row(INSTR_FMOV_X_D, 64'h123456789abcdef0, 64'h0,
                64'h123456789abcdef0, 1'b0, 1'b0, 2);
        add_row(INSTR_FMOV_D_X, 64'h7ff0000000000001, 64'h3ff0000000000000,
                64'h7ff0000000000001, 1'b0, 1'b0, 2);         // sNaN bits untouched
        add_row(INSTR_FEQ_D, 64'h3ff0000000000000, 64'h3ff0000000000000,
                64'h1, 1'b0, 1'b0, 2);
        add_row(INSTR_FLT_D, 64'h3ff0000000000000, 64'h4000000000000000,
                64'h1, 1'b0, 1'b0, 2);
        add_row(INSTR_FLT_D, 64'h4000000000000000, 64'h3ff0000000000000,
                64'h0, 1'b0, 1'b0, 2);
        add_row(INSTR_FLE_D, 64'hbff0000000000000, 64'h3ff0000000000000,
                64'h1, 1'b0, 1'b0, 2);
        add_row(INSTR_FLE_D, 64'h4000000000000000, 64'h3ff0000000000000,
                64'h0, 1'b0, 1'b0, 2);
        // Signed zeros compare equal
        add_row(INSTR_FEQ_D, 64'h0, 64'h8000000000000000, 64'h1, 1'b0, 1'b0, 2);
        add_row(INSTR_FLT_D, 64'h8000000000000000, 64'h0, 64'h0, 1'b0, 1'b0, 2);
        add_row(INSTR_FLE_D, 64'h0, 64'h8000000000000000, 64'h1, 1'b0, 1'b0, 2);
        add_row(INSTR_FEQ_D, 64'h7ff8000000000000, 64'h3ff0000000000000,
                64'h0, 1'b0, 1'b0, 2);                        // Quiet NaN, no invalid
        add_row(INSTR_FLT_D, 64'h7ff8000000000000, 64'h3ff0000000000000,
                64'h0, 1'b1, 1'b0, 2);
        add_row(INSTR_FEQ_D, 64'h7ff0000000000001, 64'h3ff0000000000000,
                64'h0, 1'b1, 1'b0, 2);
        add_row(INSTR_FMIN_D, 64'h8000000000000000, 64'h0,
                64'h8000000000000000, 1'b0, 1'b0, 2);
        add_row(INSTR_FMIN_D, 64'h0, 64'h8000000000000000,
                64'h8000000000000000, 1'b0, 1'b0, 2);
        add_row(INSTR_FMIN_D, 64'hbff0000000000000, 64'hc000000000000000,
                64'hc000000000000000, 1'b0, 1'b0, 2);
        add_row(INSTR_FMAX_D, 64'h7ff8000000000000, 64'h4000000000000000,
                64'h4000000000000000, 1'b0, 1'b0, 2);
        add_row(INSTR_FMAX_D, 64'h3ff0000000000000, 64'h7ff0000000000001,
                64'h3ff0000000000000, 1'b1, 1'b0, 2);
        add_row(INSTR_FMIN_D, 64'h7ff8000000000001, 64'hfff8000000000000,
                64'h7ff8000000000000, 1'b0, 1'b0, 2);         // Canonical NaN
        add_row(INSTR_FCVT_L_D, 64'hc004000000000000, 64'h0,
                64'hfffffffffffffffe, 1'b0, 1'b1, 3);         // -2.5 to -2
        add_row(INSTR_FCVT_WU_D, 64'h4202a05f20000000, 64'h0,
                64'hffffffffffffffff, 1'b1, 1'b0, 3);         // 1e10 saturates
        add_row(INSTR_FCVT_W_D, 64'h7ff8000000000000, 64'h0,
                64'h000000007fffffff, 1'b1, 1'b0, 3);
        add_row(INSTR_FMOV_X_D, 64'h0000000000000007, 64'h0,
                64'h0000000000000007, 1'b0, 1'b0, 2);         // Invalid from before is gone
        add_row(INSTR_FCVT_W_D, 64'hbff0000000000000, 64'h0,
                64'hffffffffffffffff, 1'b0, 1'b0, 3);
        add_row(INSTR_FCVT_LU_D, 64'hbfe0000000000000, 64'h0,
                64'h0, 1'b0, 1'b1, 3);                        // -0.5 truncates to 0
        add_row(INSTR_FCVT_LU_D, 64'h4000000000000000, 64'h0,
                64'h2, 1'b0, 1'b0, 3);
        add_row(INSTR_FCVT_D_L, 64'hffffffffffffffff, 64'h0,
                64'hbff0000000000000, 1'b0, 1'b0, 4);
        add_row(INSTR_FCVT_D_LU, 64'hffffffffffffffff, 64'h0,
                64'h43f0000000000000, 1'b0, 1'b1, 4);         // Rounds up to 2^64
        add_row(INSTR_FCVT_D_W, 64'hdeadbeef00000005, 64'h0,
                64'h4014000000000000, 1'b0, 1'b0, 4);         // High word ignored
        add_row(INSTR_FCVT_D_W, 64'h12345678fffffffe, 64'h0,
                64'hc000000000000000, 1'b0, 1'b0, 4);
        add_row(INSTR_FCVT_D_WU, 64'hffffffff80000000, 64'h0,
                64'h41e0000000000000, 1'b0, 1'b0, 4);
        add_row(INSTR_FCVT_D_L, 64'h0020000000000001, 64'h0,
                64'h4340000000000000, 1'b0, 1'b1, 4);         // Tie goes to even
        add_row(INSTR_FCVT_D_L, 64'h0020000000000003, 64'h0,
                64'h4340000000000002, 1'b0, 1'b1, 4);
        add_row(INSTR_FMOV_D_X, 64'hc000000000000000, 64'h0,
                64'hc000000000000000, 1'b0, 1'b0, 2);         // Inexact from before is gone
        add_row(INSTR_FCVT_D_LU, 64'h0, 64'h0, 64'h0, 1'b0, 1'b0, 4);
    endtask

    // Returns at the accepting edge
    task automatic send_request(input int instr, input logic [63:0] a, input logic [63:0] b);
        logic [INSTR_FPU_TOTAL-1:0] vec;
        vec = '0;
        vec[instr] = 1'b1;
        @(posedge i_clk);
        i_ena  <= 1'b1;
        i_ivec <= vec;
        i_a    <= a;
        i_b    <= b;
        @(posedge i_clk);
        i_ena  <= 1'b0;
        i_ivec <= '0;
    endtask

    // Counts clock edges after the accepting edge until o_valid is seen
    task automatic wait_valid(output int lat);
        lat = 0;
        @(negedge i_clk);
        while (!o_valid) begin
            lat++;
            @(negedge i_clk);
        end
    endtask

    task automatic run_row(input int n);
        int lat;
        send_request(t_instr[n], t_a[n], t_b[n]);
        wait_valid(lat);
        assert (lat == t_lat[n]) else
            report_mismatch($sformatf("row %0d latency %0d, expected %0d", n, lat, t_lat[n]));
        assert (o_res == t_res[n]) else
            report_mismatch($sformatf("row %0d result %h, expected %h", n, o_res, t_res[n]));
        assert (o_ex_invalidop == t_inv[n]) else
            report_mismatch($sformatf("row %0d invalid flag %b, expected %b",
                                      n, o_ex_invalidop, t_inv[n]));
        assert (o_ex_inexact == t_inx[n]) else
            report_mismatch($sformatf("row %0d inexact flag %b, expected %b",
                                      n, o_ex_inexact, t_inx[n]));
        assert (!o_busy) else report_mismatch($sformatf("row %0d busy with valid", n));
        @(negedge i_clk);
        assert (!o_valid) else report_mismatch($sformatf("row %0d valid held too long", n));
        assert (o_res == t_res[n]) else
            report_mismatch($sformatf("row %0d result not held after valid", n));
    endtask

    // Second request lands while the first conversion is in flight
    task automatic check_busy_drop;
        int lat;
        logic [INSTR_FPU_TOTAL-1:0] vec;
        vec = '0;
        vec[INSTR_FCVT_D_L] = 1'b1;
        @(posedge i_clk);
        i_ena  <= 1'b1;
        i_ivec <= vec;
        i_a    <= 64'hffffffffffffffff;
        i_b    <= 64'h0;
        @(posedge i_clk);                      // First request accepted
        vec = '0;
        vec[INSTR_FMOV_X_D] = 1'b1;
        i_ivec <= vec;
        i_a    <= 64'h5555555555555555;
        @(negedge i_clk);
        assert (o_busy) else report_mismatch("busy low after an accepted request");
        @(posedge i_clk);                      // Ignored request
        i_ena  <= 1'b0;
        i_ivec <= '0;
        wait_valid(lat);
        // Counted from the edge after acceptance
        assert (lat == 3) else
            report_mismatch($sformatf("busy test latency %0d, expected 3", lat));
        assert (o_res == 64'hbff0000000000000) else
            report_mismatch($sformatf("busy test result %h, expected bff0000000000000", o_res));
        assert (!o_ex_invalidop && !o_ex_inexact) else
            report_mismatch("busy test flags not clear");
        repeat (6) begin
            @(negedge i_clk);
            assert (!o_valid) else report_mismatch("second valid after a request while busy");
            assert (!o_busy) else report_mismatch("busy stuck high after dropped request");
        end
    endtask

    initial begin
        void'($urandom(4835));
        i_nrst <= 1'b0;
        i_ena  <= 1'b0;
        i_ivec <= '0;
        i_a    <= '0;
        i_b    <= '0;
        build_table();
        cycle_limit = t_instr.size() * 10 + 50;
        repeat (3) @(posedge i_clk);
        i_nrst <= 1'b1;
        @(negedge i_clk);
        assert (!o_valid && !o_busy) else report_mismatch("valid or busy high after reset");

        check_busy_drop();

        for (int n = 0; n < t_instr.size(); n++) begin
            repeat ($urandom % 4) @(posedge i_clk);   // Idle gap of 0 to 3 cycles
            run_row(n);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: fpu_top.sv
// FPU dispatcher: accepts one instruction, enables one unit and registers its result and flags
module fpu_top import fpu_pkg::*; (
    input  logic                       i_clk,
    input  logic                       i_nrst,
    input  logic                       i_ena,
    input  logic [INSTR_FPU_TOTAL-1:0] i_ivec,
    input  logic [63:0]                i_a,
    input  logic [63:0]                i_b,
    output logic [63:0]                o_res,
    output logic                       o_ex_invalidop,
    output logic                       o_ex_inexact,
    output logic                       o_valid,
    output logic                       o_busy
);

    logic                       r_busy;
    logic [INSTR_FPU_TOTAL-1:0] r_ivec;
    logic [63:0]                r_a;
    logic [63:0]                r_b;
    logic                       r_ena_cmp;
    logic                       r_ena_d2l;
    logic                       r_ena_l2d;
    logic                       r_ena_mov;
    logic                       r_mov_vld;   // Delays FMOV to match compare latency
    logic                       r_signed;
    logic                       r_w32;
    logic [63:0]                r_res;
    logic                       r_invalid;
    logic                       r_inexact;
    logic                       r_valid;

    logic        w_accept;
    logic [63:0] w_cmp_res;
    logic        w_cmp_inv;
    logic        w_cmp_vld;
    logic [63:0] w_d2l_res;
    logic        w_d2l_inv;
    logic        w_d2l_inx;
    logic        w_d2l_vld;
    logic [63:0] w_l2d_res;
    logic        w_l2d_inx;
    logic        w_l2d_vld;

    assign w_accept = i_ena & ~r_busy;  // Requests while busy are dropped

    fpu_compare cmp0 (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_ena       (r_ena_cmp),
        .i_eq        (r_ivec[INSTR_FEQ_D]),
        .i_lt        (r_ivec[INSTR_FLT_D]),
        .i_le        (r_ivec[INSTR_FLE_D]),
        .i_max       (r_ivec[INSTR_FMAX_D]),
        .i_min       (r_ivec[INSTR_FMIN_D]),
        .i_a         (r_a),
        .i_b         (r_b),
        .o_res       (w_cmp_res),
        .o_invalidop (w_cmp_inv),
        .o_valid     (w_cmp_vld)
    );

    fpu_d2l d2l0 (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_ena       (r_ena_d2l),
        .i_signed    (r_signed),
        .i_w32       (r_w32),
        .i_a         (r_a),
        .o_res       (w_d2l_res),
        .o_invalidop (w_d2l_inv),
        .o_inexact   (w_d2l_inx),
        .o_valid     (w_d2l_vld)
    );

    fpu_l2d l2d0 (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_ena     (r_ena_l2d),
        .i_signed  (r_signed),
        .i_w32     (r_w32),
        .i_a       (r_a),
        .o_res     (w_l2d_res),
        .o_inexact (w_l2d_inx),
        .o_valid   (w_l2d_vld)
    );

    // Operand latch
    always_ff @(posedge i_clk) begin
        if (w_accept) begin
            r_a <= i_a;
            r_b <= i_b;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_busy    <= 1'b0;
            r_ivec    <= '0;
            r_ena_cmp <= 1'b0;
            r_ena_d2l <= 1'b0;
            r_ena_l2d <= 1'b0;
            r_ena_mov <= 1'b0;
            r_mov_vld <= 1'b0;
            r_signed  <= 1'b0;
            r_w32     <= 1'b0;
            r_res     <= '0;
            r_invalid <= 1'b0;
            r_inexact <= 1'b0;
            r_valid   <= 1'b0;
        end else begin
            r_ena_cmp <= w_accept & |{i_ivec[INSTR_FEQ_D], i_ivec[INSTR_FLT_D],
                                      i_ivec[INSTR_FLE_D], i_ivec[INSTR_FMAX_D],
                                      i_ivec[INSTR_FMIN_D]};
            r_ena_d2l <= w_accept & |{i_ivec[INSTR_FCVT_L_D], i_ivec[INSTR_FCVT_LU_D],
                                      i_ivec[INSTR_FCVT_W_D], i_ivec[INSTR_FCVT_WU_D]};
            r_ena_l2d <= w_accept & |{i_ivec[INSTR_FCVT_D_L], i_ivec[INSTR_FCVT_D_LU],
                                      i_ivec[INSTR_FCVT_D_W], i_ivec[INSTR_FCVT_D_WU]};
            r_ena_mov <= w_accept & (i_ivec[INSTR_FMOV_X_D] | i_ivec[INSTR_FMOV_D_X]);
            r_mov_vld <= r_ena_mov;
            r_valid   <= 1'b0;
            if (w_accept) begin
                r_busy    <= 1'b1;
                r_ivec    <= i_ivec;
                r_signed  <= |{i_ivec[INSTR_FCVT_L_D], i_ivec[INSTR_FCVT_W_D],
                               i_ivec[INSTR_FCVT_D_L], i_ivec[INSTR_FCVT_D_W]};
                r_w32     <= |{i_ivec[INSTR_FCVT_W_D], i_ivec[INSTR_FCVT_WU_D],
                               i_ivec[INSTR_FCVT_D_W], i_ivec[INSTR_FCVT_D_WU]};
                r_invalid <= 1'b0;
                r_inexact <= 1'b0;
            end else if (r_mov_vld) begin       // Raw move of operand a
                r_busy  <= 1'b0;
                r_valid <= 1'b1;
                r_res   <= r_a;
            end else if (w_cmp_vld) begin
                r_busy    <= 1'b0;
                r_valid   <= 1'b1;
                r_res     <= w_cmp_res;
                r_invalid <= w_cmp_inv;
            end else if (w_d2l_vld) begin
                r_busy    <= 1'b0;
                r_valid   <= 1'b1;
                r_res     <= w_d2l_res;
                r_invalid <= w_d2l_inv;
                r_inexact <= w_d2l_inx;
            end else if (w_l2d_vld) begin
                r_busy    <= 1'b0;
                r_valid   <= 1'b1;
                r_res     <= w_l2d_res;
                r_inexact <= w_l2d_inx;
            end
        end
    end

    assign o_res          = r_res;
    assign o_ex_invalidop = r_invalid;
    assign o_ex_inexact   = r_inexact;
    assign o_valid        = r_valid;
    assign o_busy         = r_busy;

endmodule

// File: fpu_l2d.sv
// Integer to double converter, round to nearest even, three stage pipeline
module fpu_l2d import fpu_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_ena,
    input  logic        i_signed,
    input  logic        i_w32,
    input  logic [63:0] i_a,
    output logic [63:0] o_res,
    output logic        o_inexact,
    output logic        o_valid
);

    fpu_word_t   w_in;
    fpu_word_t   w_out;
    logic [63:0] w_val;
    logic        w_neg;
    logic [5:0]  w_lz;
    logic        w_guard;
    logic        w_sticky;
    logic        w_rnd;
    logic [52:0] w_sum;        // Rounded mantissa plus carry out

    logic        s1_vld;
    logic [63:0] s1_mag;
    logic        s1_neg;
    logic        s2_vld;
    logic [63:0] s2_norm;
    logic [10:0] s2_exp;
    logic        s2_neg;
    logic        s2_zero;

    assign w_in = i_a;

    // Low word only for the W forms
    always_comb begin
        if (!i_w32) begin
            w_val = w_in.raw;
        end else if (i_signed) begin
            w_val = {{32{w_in.raw[31]}}, w_in.raw[31:0]};
        end else begin
            w_val = {32'd0, w_in.raw[31:0]};
        end
    end

    assign w_neg = i_signed & w_val[63];

    always_ff @(posedge i_clk) begin
        s1_mag <= w_neg ? -w_val : w_val;
        s1_neg <= w_neg;
    end

    // Leading zero count, highest set bit wins
    always_comb begin
        w_lz = 6'd0;
        for (int i = 0; i < 64; i++) begin
            if (s1_mag[i]) w_lz = 6'(63 - i);
        end
    end

    always_ff @(posedge i_clk) begin
        s2_norm <= s1_mag << w_lz;
        s2_exp  <= 11'(EXP_BIAS + 63) - {5'd0, w_lz};
        s2_neg  <= s1_neg;
        s2_zero <= ~|s1_mag;
    end

    // 53 bits kept, bit 10 is guard, the rest sticky
    assign w_guard  = s2_norm[10];
    assign w_sticky = |s2_norm[9:0];
    assign w_rnd    = w_guard & (w_sticky | s2_norm[11]);
    assign w_sum    = {1'b0, s2_norm[62:11]} + {52'd0, w_rnd};

    always_comb begin
        w_out.raw = '0;                     // Zero input gives +0
        if (!s2_zero) begin
            w_out.dbl.sign = s2_neg;
            w_out.dbl.exp  = s2_exp + {10'd0, w_sum[52]};  // Carry bumps exponent
            w_out.dbl.mant = w_sum[51:0];
        end
    end

    always_ff @(posedge i_clk) begin
        if (s2_vld) begin
            o_res     <= w_out.raw;
            o_inexact <= w_guard | w_sticky;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            s1_vld  <= 1'b0;
            s2_vld  <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            s1_vld  <= i_ena;
            s2_vld  <= s1_vld;
            o_valid <= s2_vld;
        end
    end

endmodule

// File: fpu_d2l.sv
// Double to integer converter, truncating, with range saturation, two stage pipeline
module fpu_d2l import fpu_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_ena,
    input  logic        i_signed,
    input  logic        i_w32,
    input  logic [63:0] i_a,
    output logic [63:0] o_res,
    output logic        o_invalidop,
    output logic        o_inexact,
    output logic        o_valid
);

    fpu_word_t   w_op;
    logic [52:0] w_man;        // Mantissa with hidden one
    logic [5:0]  w_sh;
    logic [52:0] w_frac;
    logic [63:0] w_mag;
    logic        w_big;
    logic        w_lost;

    logic        s1_vld;
    logic [63:0] s1_mag;
    logic        s1_big;
    logic        s1_nan;
    logic        s1_sign;
    logic        s1_lost;
    logic        s1_signed;
    logic        s1_w32;

    logic [63:0] w_max_pos;
    logic [63:0] w_neg_lim;    // Magnitude of the most negative value
    logic [63:0] w_umax;
    logic [63:0] w_res;
    logic        w_inv;

    assign w_op   = i_a;
    assign w_man  = {1'b1, w_op.dbl.mant};
    assign w_sh   = 6'(w_op.dbl.exp - 11'(EXP_BIAS));
    assign w_frac = w_man << (w_sh + 6'd1);   // Bits dropped below the binary point
    assign w_big  = w_op.dbl.exp >= 11'(EXP_BIAS + 64);

    always_comb begin
        w_mag  = '0;
        w_lost = 1'b0;
        if (w_big) begin
            w_lost = 1'b0;
        end else if (w_op.dbl.exp < 11'(EXP_BIAS)) begin
            w_lost = |w_op.dbl.exp;         // Subnormals count as zero
        end else if (w_sh >= 6'd52) begin
            w_mag = {11'd0, w_man} << (w_sh - 6'd52);
        end else begin
            w_mag  = {11'd0, w_man} >> (6'd52 - w_sh);
            w_lost = |w_frac;
        end
    end

    always_ff @(posedge i_clk) begin
        s1_mag    <= w_mag;
        s1_big    <= w_big;
        s1_nan    <= (&w_op.dbl.exp) & (|w_op.dbl.mant);
        s1_sign   <= w_op.dbl.sign;
        s1_lost   <= w_lost;
        s1_signed <= i_signed;
        s1_w32    <= i_w32;
    end

    assign w_max_pos = s1_w32 ? 64'h0000_0000_7fff_ffff : 64'h7fff_ffff_ffff_ffff;
    assign w_neg_lim = s1_w32 ? 64'h0000_0000_8000_0000 : 64'h8000_0000_0000_0000;
    assign w_umax    = s1_w32 ? 64'h0000_0000_ffff_ffff : 64'hffff_ffff_ffff_ffff;

    always_comb begin
        w_res = '0;
        w_inv = 1'b0;
        if (s1_nan) begin
            w_res = s1_signed ? w_max_pos : w_umax;
            w_inv = 1'b1;
        end else if (s1_signed) begin
            if (s1_sign) begin
                w_inv = s1_big | (s1_mag > w_neg_lim);
                w_res = w_inv ? -w_neg_lim : -s1_mag;
            end else begin
                w_inv = s1_big | (s1_mag > w_max_pos);
                w_res = w_inv ? w_max_pos : s1_mag;
            end
        end else if (s1_sign) begin
            w_inv = s1_big | (|s1_mag);     // Anything at or below -1
        end else begin
            w_inv = s1_big | (s1_mag > w_umax);
            w_res = w_inv ? w_umax : s1_mag;
        end
    end

    always_ff @(posedge i_clk) begin
        if (s1_vld) begin
            o_res       <= s1_w32 ? {{32{w_res[31]}}, w_res[31:0]} : w_res;
            o_invalidop <= w_inv;
            o_inexact   <= s1_lost & ~w_inv;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            s1_vld  <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            s1_vld  <= i_ena;
            o_valid <= s1_vld;
        end
    end

endmodule

// File: fpu_compare.sv
// Double compare unit: FEQ/FLT/FLE and FMIN/FMAX with NaN rules, one cycle latency
module fpu_compare import fpu_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_ena,
    input  logic        i_eq,
    input  logic        i_lt,
    input  logic        i_le,
    input  logic        i_max,
    input  logic        i_min,
    input  logic [63:0] i_a,
    input  logic [63:0] i_b,
    output logic [63:0] o_res,
    output logic        o_invalidop,
    output logic        o_valid
);

    fpu_word_t   w_a;
    fpu_word_t   w_b;
    logic        w_nan_a;
    logic        w_nan_b;
    logic        w_snan_a;
    logic        w_snan_b;
    logic        w_any_nan;
    logic        w_both_zero;
    logic        w_mag_lt;
    logic        w_mag_gt;
    logic        w_lt;
    logic        w_eq;
    logic        w_lt_mm;      // Ordering for min/max, -0 below +0
    logic [63:0] w_res;
    logic        w_inv;

    assign w_a = i_a;
    assign w_b = i_b;

    assign w_nan_a  = (&w_a.dbl.exp) & (|w_a.dbl.mant);
    assign w_nan_b  = (&w_b.dbl.exp) & (|w_b.dbl.mant);
    assign w_snan_a = w_nan_a & ~w_a.dbl.mant[MANT_W-1];  // Quiet bit clear
    assign w_snan_b = w_nan_b & ~w_b.dbl.mant[MANT_W-1];
    assign w_any_nan = w_nan_a | w_nan_b;

    assign w_both_zero = ~|{w_a.dbl.exp, w_a.dbl.mant, w_b.dbl.exp, w_b.dbl.mant};
    assign w_mag_lt = {w_a.dbl.exp, w_a.dbl.mant} < {w_b.dbl.exp, w_b.dbl.mant};
    assign w_mag_gt = {w_a.dbl.exp, w_a.dbl.mant} > {w_b.dbl.exp, w_b.dbl.mant};

    // Sign first, then magnitude reversed for negatives
    always_comb begin
        if (w_both_zero) begin
            w_lt = 1'b0;
        end else if (w_a.dbl.sign != w_b.dbl.sign) begin
            w_lt = w_a.dbl.sign;
        end else if (w_a.dbl.sign) begin
            w_lt = w_mag_gt;
        end else begin
            w_lt = w_mag_lt;
        end
    end

    assign w_eq    = w_both_zero | (w_a.raw == w_b.raw);
    assign w_lt_mm = w_lt | (w_both_zero & w_a.dbl.sign & ~w_b.dbl.sign);

    always_comb begin
        w_res = '0;
        w_inv = 1'b0;
        if (i_eq) begin
            w_res[0] = w_eq & ~w_any_nan;
            w_inv    = w_snan_a | w_snan_b;  // Quiet NaN is silent for FEQ
        end else if (i_lt) begin
            w_res[0] = w_lt & ~w_any_nan;
            w_inv    = w_any_nan;
        end else if (i_le) begin
            w_res[0] = (w_lt | w_eq) & ~w_any_nan;
            w_inv    = w_any_nan;
        end else if (i_max | i_min) begin
            w_inv = w_snan_a | w_snan_b;
            if (w_nan_a & w_nan_b) begin
                w_res = CANON_NAN;
            end else if (w_nan_a) begin
                w_res = w_b.raw;
            end else if (w_nan_b) begin
                w_res = w_a.raw;
            end else if (i_min) begin
                w_res = w_lt_mm ? w_a.raw : w_b.raw;
            end else begin
                w_res = w_lt_mm ? w_b.raw : w_a.raw;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_ena) begin
            o_res       <= w_res;
            o_invalidop <= w_inv;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) o_valid <= 1'b0;
        else         o_valid <= i_ena;
    end

endmodule

// File: fpu_pkg.sv
// FPU shared definitions: instruction one-hot indices, double format constants, operand word
package fpu_pkg;

    // Bit positions inside the one-hot instruction vector
    localparam int INSTR_FEQ_D     = 0;
    localparam int INSTR_FLT_D     = 1;
    localparam int INSTR_FLE_D     = 2;
    localparam int INSTR_FMAX_D    = 3;
    localparam int INSTR_FMIN_D    = 4;
    localparam int INSTR_FCVT_L_D  = 5;
    localparam int INSTR_FCVT_LU_D = 6;
    localparam int INSTR_FCVT_W_D  = 7;
    localparam int INSTR_FCVT_WU_D = 8;
    localparam int INSTR_FCVT_D_L  = 9;
    localparam int INSTR_FCVT_D_LU = 10;
    localparam int INSTR_FCVT_D_W  = 11;
    localparam int INSTR_FCVT_D_WU = 12;
    localparam int INSTR_FMOV_X_D  = 13;
    localparam int INSTR_FMOV_D_X  = 14;

    localparam int INSTR_FPU_TOTAL = 15;  // Width of the instruction vector

    // IEEE 754 binary64 layout
    localparam int EXP_W    = 11;
    localparam int MANT_W   = 52;
    localparam int EXP_BIAS = 1023;

    // Quiet NaN returned by min/max when both inputs are NaN
    localparam logic [63:0] CANON_NAN = 64'h7ff8_0000_0000_0000;

    // One 64-bit operand, seen either as an integer or as a double
    typedef union packed {
        logic [63:0] raw;
        struct packed {
            logic              sign;
            logic [EXP_W-1:0]  exp;
            logic [MANT_W-1:0] mant;
        } dbl;
    } fpu_word_t;

endpackage
